/* mips_ex_pkg.sv */
`default_nettype none

package mips_ex_pkg;

    localparam int REG_W = 32;

    typedef logic [REG_W-1:0]   reg_t;
    typedef logic [2*REG_W-1:0] dreg_t;  // hi:lo
    typedef logic [4:0]         reg_addr_t;

    // opcode values follow the usual openmips numbering
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_SEB   = 8'b1100_0000,
        OP_SEH   = 8'b1100_0001,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_TEQ   = 8'b0011_0100,
        OP_TNE   = 8'b0011_0110,
        OP_TGE   = 8'b0011_0000,
        OP_TGEU  = 8'b0011_0001,
        OP_TLT   = 8'b0011_0010,
        OP_TLTU  = 8'b0011_0011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MUL   = 8'b1010_1001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011,
        OP_DIV   = 8'b0001_1010,
        OP_DIVU  = 8'b0001_1011
    } aluop_t;

    // seb/seh come back as logic results
    typedef enum logic [2:0] {
        RES_NOP   = 3'b000,
        RES_LOGIC = 3'b001,
        RES_SHIFT = 3'b010,
        RES_MOVE  = 3'b011,
        RES_ARITH = 3'b100,
        RES_MUL   = 3'b101
    } alusel_t;

    typedef struct packed {
        logic ov;
        logic trap;
    } exc_t;

endpackage

`default_nettype wire

/* ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu import mips_ex_pkg::*; (
    input  aluop_t aluop_i,
    input  reg_t   reg1_i,
    input  reg_t   reg2_i,
    output reg_t   res_o,
    output logic   ov_o,
    output logic   trap_o
);

    localparam int MSB = REG_W - 1;

    logic is_sub;
    reg_t opb;
    reg_t sum;
    logic lt_s;
    logic lt_u;

    // subtract path also serves the signed compares
    assign is_sub = aluop_i inside {OP_SUB, OP_SUBU, OP_SLT, OP_TLT, OP_TGE};
    assign opb    = is_sub ? ~reg2_i + 1'b1 : reg2_i;
    assign sum    = reg1_i + opb;

    // equal signs cannot overflow, so the difference sign decides
    assign lt_s = (reg1_i[MSB] && !reg2_i[MSB]) ||
                  ((reg1_i[MSB] == reg2_i[MSB]) && sum[MSB]);
    assign lt_u = reg1_i < reg2_i;

    // effective sign of b is flipped for a - b
    assign ov_o = (aluop_i inside {OP_ADD, OP_SUB}) &&
                  (reg1_i[MSB] == (reg2_i[MSB] ^ is_sub)) &&
                  (sum[MSB] != reg1_i[MSB]);

    always_comb begin
        case (aluop_i)
            OP_OR:   res_o = reg1_i | reg2_i;
            OP_AND:  res_o = reg1_i & reg2_i;
            OP_NOR:  res_o = ~(reg1_i | reg2_i);
            OP_XOR:  res_o = reg1_i ^ reg2_i;
            OP_SLL:  res_o = reg2_i << reg1_i[4:0];
            OP_SRL:  res_o = reg2_i >> reg1_i[4:0];
            OP_SRA:  res_o = reg_t'($signed(reg2_i) >>> reg1_i[4:0]);
            OP_SEB:  res_o = {{(REG_W-8){reg2_i[7]}}, reg2_i[7:0]};
            OP_SEH:  res_o = {{(REG_W-16){reg2_i[15]}}, reg2_i[15:0]};
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                res_o = sum;
            end
            OP_SLT:  res_o = reg_t'(lt_s);
            OP_SLTU: res_o = reg_t'(lt_u);
            default: res_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_TEQ:  trap_o = reg1_i == reg2_i;
            OP_TNE:  trap_o = reg1_i != reg2_i;
            OP_TGE:  trap_o = !lt_s;
            OP_TGEU: trap_o = !lt_u;
            OP_TLT:  trap_o = lt_s;
            OP_TLTU: trap_o = lt_u;
            default: trap_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
    parameter int DIV_W = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start_i,
    input  logic               signed_i,
    input  logic [DIV_W-1:0]   a_i,
    input  logic [DIV_W-1:0]   b_i,
    output logic               ready_o,
    output logic [2*DIV_W-1:0] result_o
);

    localparam int CNT_W = $clog2(DIV_W);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

    div_state_t state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [DIV_W-1:0] rem_q;
    logic [DIV_W-1:0] quo_q;  // dividend shifts out, quotient shifts in
    logic [DIV_W-1:0] den_q;
    logic neg_quo_q;
    logic neg_rem_q;
    logic [DIV_W-1:0] a_mag;
    logic [DIV_W-1:0] b_mag;
    logic [DIV_W:0] trial;
    logic [DIV_W-1:0] quo_fix;
    logic [DIV_W-1:0] rem_fix;

    assign a_mag = (signed_i && a_i[DIV_W-1]) ? -a_i : a_i;
    assign b_mag = (signed_i && b_i[DIV_W-1]) ? -b_i : b_i;

    // msb set means the trial subtract borrowed
    assign trial = {rem_q, quo_q[DIV_W-1]} - {1'b0, den_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_BUSY;
                        cnt_q   <= '0;
                    end
                end
                DIV_BUSY: begin
                    if (!start_i) begin
                        state_q <= DIV_IDLE;  // cancelled
                    end else if (cnt_q == CNT_W'(DIV_W - 1)) begin
                        state_q <= DIV_DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                DIV_DONE: begin
                    if (!start_i) begin
                        state_q <= DIV_IDLE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            rem_q     <= '0;
            quo_q     <= a_mag;
            den_q     <= b_mag;
            neg_quo_q <= signed_i && (a_i[DIV_W-1] ^ b_i[DIV_W-1]);
            neg_rem_q <= signed_i && a_i[DIV_W-1];
        end else if (state_q == DIV_BUSY) begin
            if (!trial[DIV_W]) begin
                rem_q <= trial[DIV_W-1:0];
                quo_q <= {quo_q[DIV_W-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[DIV_W-2:0], quo_q[DIV_W-1]};
                quo_q <= {quo_q[DIV_W-2:0], 1'b0};
            end
        end
    end

    assign quo_fix  = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;
    assign result_o = {rem_fix, quo_fix};
    assign ready_o  = state_q == DIV_DONE;

    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        ready_o |=> !ready_o);

endmodule

`default_nettype wire

/* ex_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_muldiv import mips_ex_pkg::*; #(
    parameter int DIV_W = REG_W
) (
    input  logic   clk,
    input  logic   rst,
    input  aluop_t aluop_i,
    input  reg_t   reg1_i,
    input  reg_t   reg2_i,
    input  logic   div_ready_i,
    input  dreg_t  div_result_i,
    output reg_t   lo_word_o,
    output reg_t   hilo_word_o,
    output logic   stall_o,
    output logic   div_start_o,
    output logic   div_signed_o,
    output reg_t   div_a_o,
    output reg_t   div_b_o
);

    localparam int RUN_W = $clog2(DIV_W + 5);

    logic is_mul;
    logic mul_signed;
    logic is_acc;
    logic is_msub;
    logic is_div;
    logic phase_q;  // 1 in the result cycle
    logic [2*REG_W-1:0] prod_s;
    dreg_t prod_u;
    dreg_t prod_q;
    dreg_t mul_res;
    reg_t hi_q;
    reg_t lo_q;
    logic [RUN_W-1:0] stall_run;

    assign is_mul     = aluop_i inside {OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU,
                                        OP_MSUB, OP_MSUBU};
    assign mul_signed = aluop_i inside {OP_MULT, OP_MUL, OP_MADD, OP_MSUB};
    assign is_acc     = aluop_i inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    assign is_msub    = aluop_i inside {OP_MSUB, OP_MSUBU};
    assign is_div     = aluop_i inside {OP_DIV, OP_DIVU};

    assign prod_s = $signed(reg1_i) * $signed(reg2_i);
    assign prod_u = reg1_i * reg2_i;

    always_ff @(posedge clk) begin
        if (is_mul && !phase_q) begin
            prod_q <= mul_signed ? prod_s : prod_u;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= 1'b0;
        end else begin
            phase_q <= is_mul && !phase_q;
        end
    end

    always_comb begin
        if (is_msub) begin
            mul_res = {hi_q, lo_q} + (~prod_q + 1'b1);
        end else if (is_acc) begin
            mul_res = {hi_q, lo_q} + prod_q;
        end else begin
            mul_res = prod_q;
        end
    end

    assign lo_word_o = mul_res[REG_W-1:0];

    // divider is held in start until it answers
    assign div_start_o  = is_div && !div_ready_i;
    assign div_signed_o = aluop_i == OP_DIV;
    assign div_a_o      = is_div ? reg1_i : '0;
    assign div_b_o      = is_div ? reg2_i : '0;

    assign stall_o = (is_mul && !phase_q) || div_start_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (is_mul && phase_q && aluop_i != OP_MUL) begin
            {hi_q, lo_q} <= mul_res;
        end else if (is_div && div_ready_i) begin
            {hi_q, lo_q} <= div_result_i;  // remainder goes to hi
        end else if (aluop_i == OP_MTHI) begin
            hi_q <= reg1_i;
        end else if (aluop_i == OP_MTLO) begin
            lo_q <= reg1_i;
        end
    end

    always_comb begin
        case (aluop_i)
            OP_MFHI: hilo_word_o = hi_q;
            OP_MFLO: hilo_word_o = lo_q;
            default: hilo_word_o = '0;
        endcase
    end

    // length of the current stall run
    always_ff @(posedge clk) begin
        if (rst || !stall_o) begin
            stall_run <= '0;
        end else if (stall_run != '1) begin
            stall_run <= stall_run + 1'b1;
        end
    end

    a_stall_bound: assert property (@(posedge clk) disable iff (rst)
        stall_o |-> (int'(stall_run) < DIV_W + 3));

endmodule

`default_nettype wire

/* ex_writeback_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_writeback_sel import mips_ex_pkg::*; (
    input  alusel_t   alusel_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    input  reg_t      alu_res_i,
    input  reg_t      mul_lo_i,
    input  reg_t      hilo_word_i,
    input  logic      ov_i,
    input  logic      trap_i,
    input  logic      md_stall_i,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output reg_t      wdata_o,
    output exc_t      except_o,
    output logic      stallreq_o
);

    always_comb begin
        case (alusel_i)
            RES_LOGIC, RES_SHIFT, RES_ARITH: begin
                wdata_o = alu_res_i;
            end
            RES_MOVE: wdata_o = hilo_word_i;  // mfhi/mflo
            RES_MUL:  wdata_o = mul_lo_i;
            default:  wdata_o = '0;
        endcase
    end

    assign wd_o = wd_i;

    // overflowed add/sub must not reach the register file
    assign wreg_o = wreg_i && !ov_i && !md_stall_i;

    assign except_o   = '{ov: ov_i, trap: trap_i};
    assign stallreq_o = md_stall_i;

endmodule

`default_nettype wire

/* ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top import mips_ex_pkg::*; #(
    parameter int DIV_W = REG_W
) (
    input  logic      clk,
    input  logic      rst,
    input  aluop_t    aluop_i,
    input  alusel_t   alusel_i,
    input  reg_t      reg1_i,
    input  reg_t      reg2_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output reg_t      wdata_o,
    output exc_t      except_o,
    output logic      stallreq_o
);

    reg_t alu_res;
    logic alu_ov;
    logic alu_trap;
    reg_t mul_lo;
    reg_t move_hilo;
    logic md_stall;
    logic div_start;
    logic div_signed;
    reg_t div_a;
    reg_t div_b;
    logic div_ready;
    dreg_t div_result;

    ex_alu u_alu (
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .res_o   (alu_res),
        .ov_o    (alu_ov),
        .trap_o  (alu_trap)
    );

    ex_muldiv #(.DIV_W(DIV_W)) u_muldiv (
        .clk          (clk),
        .rst          (rst),
        .aluop_i      (aluop_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .div_ready_i  (div_ready),
        .div_result_i (div_result),
        .lo_word_o    (mul_lo),
        .hilo_word_o  (move_hilo),
        .stall_o      (md_stall),
        .div_start_o  (div_start),
        .div_signed_o (div_signed),
        .div_a_o      (div_a),
        .div_b_o      (div_b)
    );

    div_unit #(.DIV_W(DIV_W)) u_div (
        .clk      (clk),
        .rst      (rst),
        .start_i  (div_start),
        .signed_i (div_signed),
        .a_i      (div_a),
        .b_i      (div_b),
        .ready_o  (div_ready),
        .result_o (div_result)
    );

    ex_writeback_sel u_wb_sel (
        .alusel_i    (alusel_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .alu_res_i   (alu_res),
        .mul_lo_i    (mul_lo),
        .hilo_word_i (move_hilo),
        .ov_i        (alu_ov),
        .trap_i      (alu_trap),
        .md_stall_i  (md_stall),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o),
        .except_o    (except_o),
        .stallreq_o  (stallreq_o)
    );

endmodule

`default_nettype wire

/* tb_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex import mips_ex_pkg::*; ();

    localparam int DIV_W   = REG_W;
    localparam int NUM_OPS = 400;
    localparam int MAX_CYC = NUM_OPS * (DIV_W + 4) + 20;

    logic      clk = 1'b0;
    logic      rst;
    aluop_t    aluop;
    alusel_t   alusel;
    reg_t      reg1;
    reg_t      reg2;
    reg_addr_t wd;
    logic      wreg;
    reg_addr_t wd_out;
    logic      wreg_out;
    reg_t      wdata;
    exc_t      except_flags;
    logic      stallreq;

    integer seed = 70413;
    int     cycles = 0;
    reg_t   hi_m = '0;  // model hi/lo
    reg_t   lo_m = '0;

    aluop_t op_list [35] = '{
        OP_NOP, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA, OP_SEB,
        OP_SEH, OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_TEQ,
        OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU, OP_MFHI, OP_MTHI, OP_MFLO,
        OP_MTLO, OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU, OP_MSUB,
        OP_MSUBU, OP_DIV, OP_DIVU
    };

    ex_top #(.DIV_W(DIV_W)) DUT (
        .clk        (clk),
        .rst        (rst),
        .aluop_i    (aluop),
        .alusel_i   (alusel),
        .reg1_i     (reg1),
        .reg2_i     (reg2),
        .wd_i       (wd),
        .wreg_i     (wreg),
        .wd_o       (wd_out),
        .wreg_o     (wreg_out),
        .wdata_o    (wdata),
        .except_o   (except_flags),
        .stallreq_o (stallreq)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("timeout after %0d cycles, stage never finished", cycles);
            $display("** FAIL **");
            $fatal(1, "run stopped");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input reg_t got, input reg_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_exc(input string name, input exc_t got, input exc_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    function automatic alusel_t class_of(input aluop_t op);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SEB, OP_SEH: return RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA: return RES_SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU: return RES_ARITH;
            OP_MFHI, OP_MFLO: return RES_MOVE;
            OP_MUL: return RES_MUL;
            default: return RES_NOP;  // traps, hi/lo writers
        endcase
    endfunction

    // reference model, also returns the next hi/lo
    task automatic predict(input aluop_t op, input reg_t a, input reg_t b,
                           output reg_t res, output logic ov, output logic trap,
                           output reg_t hi_n, output reg_t lo_n);
        longint sa;
        longint sb;
        longint s;
        longint q;
        longint prod_s;
        logic [63:0] prod_u;
        logic [63:0] acc;
        sa     = $signed(a);
        sb     = $signed(b);
        prod_s = sa * sb;
        prod_u = {32'b0, a} * {32'b0, b};
        acc    = {hi_m, lo_m};
        res    = '0;
        ov     = 1'b0;
        trap   = 1'b0;
        hi_n   = hi_m;
        lo_n   = lo_m;
        s      = 0;
        case (op)
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_NOR:  res = ~(a | b);
            OP_SLL:  res = b << a[4:0];
            OP_SRL:  res = b >> a[4:0];
            OP_SRA: begin
                s   = sb >>> a[4:0];
                res = s[31:0];
            end
            OP_SEB: begin
                s   = $signed(b[7:0]);
                res = s[31:0];
            end
            OP_SEH: begin
                s   = $signed(b[15:0]);
                res = s[31:0];
            end
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                s   = (op inside {OP_ADD, OP_ADDU}) ? sa + sb : sa - sb;
                res = s[31:0];
                ov  = (op inside {OP_ADD, OP_SUB}) &&
                      (s > 64'sd2147483647 || s < -64'sd2147483648);
            end
            OP_SLT:  res = reg_t'(sa < sb);
            OP_SLTU: res = reg_t'(a < b);
            OP_TEQ:  trap = a == b;
            OP_TNE:  trap = a != b;
            OP_TGE:  trap = sa >= sb;
            OP_TGEU: trap = a >= b;
            OP_TLT:  trap = sa < sb;
            OP_TLTU: trap = a < b;
            OP_MFHI: res = hi_m;
            OP_MFLO: res = lo_m;
            OP_MTHI: hi_n = a;
            OP_MTLO: lo_n = a;
            OP_MULT:  {hi_n, lo_n} = prod_s;
            OP_MULTU: {hi_n, lo_n} = prod_u;
            OP_MUL:   res = prod_s[31:0];
            OP_MADD:  {hi_n, lo_n} = acc + prod_s;
            OP_MADDU: {hi_n, lo_n} = acc + prod_u;
            OP_MSUB:  {hi_n, lo_n} = acc - prod_s;
            OP_MSUBU: {hi_n, lo_n} = acc - prod_u;
            OP_DIV: begin
                q    = sa / sb;  // truncates toward zero
                s    = sa % sb;  // keeps dividend sign
                hi_n = s[31:0];
                lo_n = q[31:0];
            end
            OP_DIVU: begin
                hi_n = reg_t'({32'b0, a} % {32'b0, b});
                lo_n = reg_t'({32'b0, a} / {32'b0, b});
            end
            default: res = '0;
        endcase
    endtask

    task automatic pick_operands(input aluop_t op, output reg_t a, output reg_t b);
        int r;
        r = {$random(seed)} % 8;
        a = $random(seed);
        b = $random(seed);
        if (r == 0) b = a;
        else if (r == 1) a = 32'h8000_0000;
        else if (r == 2) b = 32'hffff_ffff;
        else if (r == 3) b = b >> 20;  // small divisors
        else if (r == 4) begin
            a = 32'h8000_0000;
            b = 32'hffff_ffff;
        end
        if (op inside {OP_DIV, OP_DIVU}) begin
            while (b == '0) b = $random(seed);
        end
    endtask

    // called on a rising edge, returns on a rising edge
    task automatic run_op(input aluop_t op, input reg_t a, input reg_t b,
                          input reg_addr_t dst, input logic wr);
        int   stalls;
        reg_t res;
        logic ov;
        logic trap;
        reg_t hi_n;
        reg_t lo_n;
        aluop  <= op;
        alusel <= class_of(op);
        reg1   <= a;
        reg2   <= b;
        wd     <= dst;
        wreg   <= wr;
        stalls = 0;
        @(negedge clk);
        while (stallreq) begin
            check_bit("wreg_o while stalled", wreg_out, 1'b0);
            stalls++;
            @(negedge clk);
        end
        if (op inside {OP_DIV, OP_DIVU}) begin
            if (stalls == 0 || stalls > DIV_W + 2) begin
                fail_run($sformatf("divide stalled for %0d cycles", stalls));
            end
        end else if (op inside {OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU,
                                OP_MSUB, OP_MSUBU}) begin
            check_word("multiply stall cycles", reg_t'(stalls), 32'd1);
        end else begin
            check_word("stall cycles", reg_t'(stalls), 32'd0);
        end
        predict(op, a, b, res, ov, trap, hi_n, lo_n);
        check_word("wdata_o", wdata, res);
        check_addr("wd_o", wd_out, dst);
        check_bit("wreg_o", wreg_out, wr && !ov);
        check_exc("except_o", except_flags, exc_t'({ov, trap}));
        hi_m = hi_n;
        lo_m = lo_n;
        @(posedge clk);
    endtask

    initial begin
        aluop_t    op;
        reg_t      a;
        reg_t      b;
        reg_addr_t dst;
        logic      wr;
        logic      wrote_hilo;
        reg_t      r;
        rst    = 1'b1;
        aluop  = OP_NOP;
        alusel = RES_NOP;
        reg1   = '0;
        reg2   = '0;
        wd     = '0;
        wreg   = 1'b0;
        wrote_hilo = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("stallreq_o after reset", stallreq, 1'b0);
        check_bit("wreg_o after reset", wreg_out, 1'b0);
        check_exc("except_o after reset", except_flags, '0);
        @(posedge clk);
        for (int n = 0; n < NUM_OPS; n++) begin
            op = op_list[{$random(seed)} % 35];
            if (wrote_hilo && ({$random(seed)} % 2 == 0)) begin
                op = ({$random(seed)} % 2 == 0) ? OP_MFHI : OP_MFLO;  // read back
            end
            pick_operands(op, a, b);
            r   = $random(seed);
            dst = r[4:0];
            wr  = r[8];
            run_op(op, a, b, dst, wr);
            wrote_hilo = op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB,
                                    OP_MSUBU, OP_DIV, OP_DIVU, OP_MTHI, OP_MTLO};
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* ex_top.f */
mips_ex_pkg.sv
ex_alu.sv
div_unit.sv
ex_muldiv.sv
ex_writeback_sel.sv
ex_top.sv
tb_ex.sv

/* Makefile */
TOP := tb_ex

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_ex with Verilator, run it and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal -f ex_top.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
